// ==== all.f ====
design/gesture_pkg.sv
design/album_pkg.sv
design/ui_cmd_if.sv
design/patch_command_decode.sv
design/mode_register.sv
design/snapshot_capture.sv
design/album_navigator.sv
design/gesture_ui_top.sv
dv/ui_checker.sv
dv/tb_gesture_ui.sv

// ==== design/album_navigator.sv ====
`default_nettype none

module album_navigator (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_gesture_add,
	input  logic                i_gesture_sub,
	input  logic                i_frame_rdone,
	ui_cmd_if.view              ui,
	output album_pkg::pic_idx_t o_display_num,
	output album_pkg::addr_t    o_wr_base,
	output album_pkg::addr_t    o_rd_base,
	output logic                o_reload
);

	album_pkg::pic_idx_t disp_q;
	album_pkg::pic_idx_t disp_d;
	// Buffer shown on screen
	album_pkg::pic_idx_t rd_idx;
	// Newest stored picture
	album_pkg::pic_idx_t last_idx;

	logic display;
	logic step_add;
	logic step_sub;
	// Display bit one cycle ago
	logic disp_prev_q;
	logic disp_change;
	// Read side needs a new base
	logic pend_q;
	logic reload_q;

	assign display  = ui.view_mode[gesture_pkg::MODE_DISPLAY];
	assign last_idx = ui.pic_count - 1'b1;

	// Browse steps, add wins
	assign step_add = display && i_gesture_add;
	assign step_sub = display && i_gesture_sub && !i_gesture_add;

	assign disp_change = display ^ disp_prev_q;

	// ==============================
	// Browse index
	// ==============================

	always_comb begin
		disp_d = disp_q;
		if (step_add) begin
			// Wrap past the newest picture
			disp_d = (disp_q == last_idx) ? '0 : disp_q + 1'b1;
		end else if (step_sub) begin
			disp_d = (disp_q == '0) ? last_idx : disp_q - 1'b1;
		end
	end

	// Browse in display mode, else live slot
	assign rd_idx = display ? disp_q : ui.pic_count;

	// Base addresses in frame-buffer words
	assign o_rd_base = album_pkg::addr_t'(rd_idx) * album_pkg::addr_t'(album_pkg::FRAME_WORDS);
	assign o_wr_base = album_pkg::addr_t'(ui.pic_count)
		* album_pkg::addr_t'(album_pkg::FRAME_WORDS);

	// ==============================
	// Reload handshake
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			disp_q      <= '0;
			disp_prev_q <= 1'b0;
			pend_q      <= 1'b0;
			reload_q    <= 1'b0;
		end else begin
			disp_q      <= disp_d;
			disp_prev_q <= display;
			// Latest change wins over a release
			if (step_add || step_sub || disp_change) begin
				pend_q <= 1'b1;
			end else if (i_frame_rdone) begin
				pend_q <= 1'b0;
			end
			// Reader reloads between frames
			reload_q <= pend_q && i_frame_rdone;
		end
	end

	assign o_display_num = disp_q;
	assign o_reload      = reload_q;

	// Browse index stays inside the stored pictures
	a_browse_in_album: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(ui.pic_count != '0) |-> (disp_q < ui.pic_count));

endmodule

`default_nettype wire

// ==== design/album_pkg.sv ====
`default_nettype none

package album_pkg;

	// ==============================
	// Album and frame buffer
	// ==============================

	// Album slot or browse index
	typedef logic [3:0] pic_idx_t;

	// One 640x480 picture, two pixels per word
	localparam int FRAME_WORDS = 640 * 480 / 2;

	// Frame-buffer word address
	localparam int ADDR_W = 23;

	typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== design/gesture_pkg.sv ====
`default_nettype none

package gesture_pkg;

	// ==============================
	// Finger patch overlay
	// ==============================

	// Patches on the screen overlay
	localparam int PATCH_W = 48;

	// One hit flag per patch
	typedef logic [PATCH_W-1:0] patch_vec_t;

	// Patches that carry a command
	localparam int P_CHANGE_MODE  = 0;
	localparam int P_RED          = 2;
	localparam int P_YELLOW       = 3;
	localparam int P_BLUE         = 4;
	localparam int P_CONTROL_BACK = 6;
	localparam int P_CONTROL      = 7;
	localparam int P_WRITE_BACK   = 24;
	localparam int P_WRITE        = 32;
	localparam int P_SHOT         = 40;

	// ==============================
	// View mode and paint colour
	// ==============================

	// Bit positions inside mode_t
	localparam int MODE_DISPLAY   = 0;
	localparam int MODE_INTERFACE = 1;

	typedef logic [1:0] mode_t;

	// Paint colour codes
	typedef enum logic [1:0] {
		COLOR_RED    = 2'd0,
		COLOR_YELLOW = 2'd1,
		COLOR_BLUE   = 2'd2
	} color_t;

endpackage

`default_nettype wire

// ==== design/gesture_ui_top.sv ====
`default_nettype none

module gesture_ui_top #(
	parameter int SNAP_DELAY = 100_000_000,
	parameter int MAX_PICS   = 7
) (
	input  logic                    CLOCK2_50,
	input  logic                    pic_rst,
	input  gesture_pkg::patch_vec_t i_patch,
	input  logic                    i_key_busy,
	input  logic                    i_skin_change,
	input  logic                    i_frame_wdone,
	input  logic                    i_frame_rdone,
	input  logic                    i_gesture_add,
	input  logic                    i_gesture_sub,
	output gesture_pkg::mode_t      o_view_mode,
	output logic                    o_write_mode,
	output gesture_pkg::color_t     o_varied_color,
	output album_pkg::pic_idx_t     o_pic_count,
	output album_pkg::pic_idx_t     o_display_num,
	output album_pkg::addr_t        o_wr_base,
	output album_pkg::addr_t        o_rd_base,
	output logic                    o_snap_req,
	output logic                    o_reload
);

	// Command and mode bus
	ui_cmd_if ui ();

	// Patch flags to command pulses
	patch_command_decode u_decode (
		.i_clk      (CLOCK2_50),
		.i_rst_n    (pic_rst),
		.i_patch    (i_patch),
		.i_key_busy (i_key_busy),
		.ui         (ui.cmd)
	);

	// View, write mode, colour
	mode_register u_mode (
		.i_clk          (CLOCK2_50),
		.i_rst_n        (pic_rst),
		.i_skin_change  (i_skin_change),
		.ui             (ui.mode),
		.o_varied_color (o_varied_color)
	);

	// Delayed screen shot
	snapshot_capture #(
		.SNAP_DELAY (SNAP_DELAY),
		.MAX_PICS   (MAX_PICS)
	) u_snap (
		.i_clk         (CLOCK2_50),
		.i_rst_n       (pic_rst),
		.i_frame_wdone (i_frame_wdone),
		.ui            (ui.shot),
		.o_snap_req    (o_snap_req)
	);

	// Browsing and buffer bases
	album_navigator u_nav (
		.i_clk         (CLOCK2_50),
		.i_rst_n       (pic_rst),
		.i_gesture_add (i_gesture_add),
		.i_gesture_sub (i_gesture_sub),
		.i_frame_rdone (i_frame_rdone),
		.ui            (ui.view),
		.o_display_num (o_display_num),
		.o_wr_base     (o_wr_base),
		.o_rd_base     (o_rd_base),
		.o_reload      (o_reload)
	);

	// Mode state out to the pins
	assign o_view_mode  = ui.view_mode;
	assign o_write_mode = ui.write_mode;
	assign o_pic_count  = ui.pic_count;

endmodule

`default_nettype wire

// ==== design/mode_register.sv ====
`default_nettype none

module mode_register (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_skin_change,
	ui_cmd_if.mode              ui,
	output gesture_pkg::color_t o_varied_color
);

	gesture_pkg::mode_t  view_q;
	gesture_pkg::mode_t  view_d;
	logic                write_q;
	logic                write_d;
	gesture_pkg::color_t color_q;
	gesture_pkg::color_t color_d;

	// Shorthand for the two view bits
	logic disp_on;
	logic intf_on;
	// Paint allowed in this view
	logic paint_ok;
	// Write toggle request
	logic write_cmd;

	assign disp_on   = view_q[gesture_pkg::MODE_DISPLAY];
	assign intf_on   = view_q[gesture_pkg::MODE_INTERFACE];
	assign paint_ok  = intf_on && !disp_on;
	// Off -> write patch, on -> write-back patch
	assign write_cmd = write_q ? ui.cmd_write_back : ui.cmd_write;

	always_comb begin
		view_d  = view_q;
		write_d = write_q;
		color_d = color_q;

		// Display bit
		// Skin change drops back to live view
		if (disp_on && i_skin_change) begin
			view_d[gesture_pkg::MODE_DISPLAY] = 1'b0;
		end else if (!disp_on && ui.cmd_change_mode && (ui.pic_count != '0)) begin
			// Nothing to browse in an empty album
			view_d[gesture_pkg::MODE_DISPLAY] = 1'b1;
		end

		// Interface bit
		if (!intf_on && ui.cmd_control) begin
			view_d[gesture_pkg::MODE_INTERFACE] = 1'b1;
		end else if (intf_on && ui.cmd_control_back) begin
			view_d[gesture_pkg::MODE_INTERFACE] = 1'b0;
		end

		// Write mode
		// Entering or leaving the button panel ends painting
		if (ui.cmd_control || (intf_on && ui.cmd_control_back)) begin
			write_d = 1'b0;
		end else if (paint_ok && write_cmd) begin
			write_d = ~write_q;
		end

		// Colour pick, red first if several
		if (write_q && !disp_on) begin
			if (ui.cmd_red) begin
				color_d = gesture_pkg::COLOR_RED;
			end else if (ui.cmd_yellow) begin
				color_d = gesture_pkg::COLOR_YELLOW;
			end else if (ui.cmd_blue) begin
				color_d = gesture_pkg::COLOR_BLUE;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			view_q  <= '0;
			write_q <= 1'b0;
			color_q <= gesture_pkg::COLOR_RED;
		end else begin
			view_q  <= view_d;
			write_q <= write_d;
			color_q <= color_d;
		end
	end

	assign ui.view_mode    = view_q;
	assign ui.write_mode   = write_q;
	assign o_varied_color  = color_q;

	// Painting only inside the button panel
	a_write_needs_intf: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		write_q |-> intf_on);

endmodule

`default_nettype wire

// ==== design/patch_command_decode.sv ====
`default_nettype none

module patch_command_decode (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  gesture_pkg::patch_vec_t i_patch,
	input  logic                    i_key_busy,
	ui_cmd_if.cmd                   ui
);

	localparam int N_CMD = 9;

	// Gated flags this cycle
	logic [N_CMD-1:0] flag_now;
	// Gated flags from last edge
	logic [N_CMD-1:0] flag_q;
	// Registered rising edges
	logic [N_CMD-1:0] pulse_q;

	// Pick used patches, bit 0 first
	// Busy key masks every patch
	assign flag_now = {
		i_patch[gesture_pkg::P_SHOT],
		i_patch[gesture_pkg::P_BLUE],
		i_patch[gesture_pkg::P_YELLOW],
		i_patch[gesture_pkg::P_RED],
		i_patch[gesture_pkg::P_WRITE_BACK],
		i_patch[gesture_pkg::P_WRITE],
		i_patch[gesture_pkg::P_CONTROL_BACK],
		i_patch[gesture_pkg::P_CONTROL],
		i_patch[gesture_pkg::P_CHANGE_MODE]
	} & {N_CMD{~i_key_busy}};

	// Edge detect
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			flag_q  <= '0;
			pulse_q <= '0;
		end else begin
			flag_q  <= flag_now;
			// High only on first cycle of a touch
			pulse_q <= flag_now & ~flag_q;
		end
	end

	// Fan out to command bus
	assign ui.cmd_change_mode  = pulse_q[0];
	assign ui.cmd_control      = pulse_q[1];
	assign ui.cmd_control_back = pulse_q[2];
	assign ui.cmd_write        = pulse_q[3];
	assign ui.cmd_write_back   = pulse_q[4];
	assign ui.cmd_red          = pulse_q[5];
	assign ui.cmd_yellow       = pulse_q[6];
	assign ui.cmd_blue         = pulse_q[7];
	assign ui.cmd_shot         = pulse_q[8];

endmodule

`default_nettype wire

// ==== design/snapshot_capture.sv ====
`default_nettype none

module snapshot_capture #(
	parameter int SNAP_DELAY = 100_000_000,
	parameter int MAX_PICS   = 7
) (
	input  logic    i_clk,
	input  logic    i_rst_n,
	input  logic    i_frame_wdone,
	ui_cmd_if.shot  ui,
	output logic    o_snap_req
);

	// Wide enough to hold SNAP_DELAY
	localparam int CNT_W = (SNAP_DELAY > 0) ? $clog2(SNAP_DELAY + 1) : 1;

	typedef enum logic {
		SNAP_IDLE,
		SNAP_COUNT
	} snap_state_t;

	snap_state_t         state_q;
	logic [CNT_W-1:0]    cnt_q;
	album_pkg::pic_idx_t pic_q;
	// Capture done, waiting for a frame write
	logic                pend_q;
	logic                req_q;

	logic shot_ok;
	logic capture;
	logic room;

	// ==============================
	// Shot gating
	// ==============================

	// Shot only from the button panel in live view
	assign shot_ok = ui.cmd_shot && ui.view_mode[gesture_pkg::MODE_INTERFACE]
		&& !ui.view_mode[gesture_pkg::MODE_DISPLAY];

	// Last count cycle, a fresh shot restarts instead
	assign capture = (state_q == SNAP_COUNT) && (cnt_q == CNT_W'(SNAP_DELAY)) && !shot_ok;

	// Free album slot left
	assign room = pic_q < album_pkg::pic_idx_t'(MAX_PICS);

	// Delay timer
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= SNAP_IDLE;
			cnt_q   <= '0;
		end else if (shot_ok) begin
			state_q <= SNAP_COUNT;
			cnt_q   <= '0;
		end else if (capture) begin
			state_q <= SNAP_IDLE;
			cnt_q   <= '0;
		end else if (state_q == SNAP_COUNT) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// ==============================
	// Slot counter and request
	// ==============================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pic_q  <= '0;
			pend_q <= 1'b0;
			req_q  <= 1'b0;
		end else begin
			if (capture && room) begin
				pic_q  <= pic_q + 1'b1;
				pend_q <= 1'b1;
			end else if (i_frame_wdone) begin
				pend_q <= 1'b0;
			end
			// Store starts at the next frame boundary
			req_q <= pend_q && i_frame_wdone;
		end
	end

	assign ui.pic_count = pic_q;
	assign o_snap_req   = req_q;

	// Album never overflows
	a_pic_count_cap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		pic_q <= album_pkg::pic_idx_t'(MAX_PICS));

endmodule

`default_nettype wire

// ==== design/ui_cmd_if.sv ====
`default_nettype none

interface ui_cmd_if;

	// One-cycle command pulses
	logic cmd_change_mode;
	logic cmd_control;
	logic cmd_control_back;
	logic cmd_write;
	logic cmd_write_back;
	logic cmd_red;
	logic cmd_yellow;
	logic cmd_blue;
	logic cmd_shot;

	// Current mode state
	gesture_pkg::mode_t  view_mode;
	logic                write_mode;
	album_pkg::pic_idx_t pic_count;

	// Patch decoder
	modport cmd (
		output cmd_change_mode, cmd_control, cmd_control_back, cmd_write,
		       cmd_write_back, cmd_red, cmd_yellow, cmd_blue, cmd_shot
	);

	// Mode register block
	modport mode (
		input  cmd_change_mode, cmd_control, cmd_control_back, cmd_write,
		       cmd_write_back, cmd_red, cmd_yellow, cmd_blue, pic_count,
		output view_mode, write_mode
	);

	// Screen shot unit
	modport shot (
		input  cmd_shot, view_mode,
		output pic_count
	);

	// Album browser
	modport view (
		input view_mode, pic_count
	);

endinterface

`default_nettype wire

// ==== dv/tb_gesture_ui.sv ====
`default_nettype none

module tb_gesture_ui;

	localparam int SNAP_DELAY  = 16;
	localparam int MAX_PICS    = 7;
	// Minimum run, then stop once the album is full
	localparam int MIN_CYCLES  = 3000;
	localparam int RUN_TIMEOUT = 50000;

	logic                    CLOCK2_50;
	logic                    pic_rst;
	gesture_pkg::patch_vec_t i_patch;
	logic                    i_key_busy;
	logic                    i_skin_change;
	logic                    i_frame_wdone;
	logic                    i_frame_rdone;
	logic                    i_gesture_add;
	logic                    i_gesture_sub;
	logic [1:0]              o_view_mode;
	logic                    o_write_mode;
	gesture_pkg::color_t     o_varied_color;
	logic [3:0]              o_pic_count;
	logic [3:0]              o_display_num;
	logic [22:0]             o_wr_base;
	logic [22:0]             o_rd_base;
	logic                    o_snap_req;
	logic                    o_reload;

	int          errors;
	int          checks;
	logic [31:0] rng_state;
	logic [31:0] r_patch;
	logic [31:0] r_ctrl;
	int          cycle;
	int          snaps;
	int          reloads;
	logic        goal_met;

	gesture_ui_top #(
		.SNAP_DELAY (SNAP_DELAY),
		.MAX_PICS   (MAX_PICS)
	) i_gesture_ui_top (
		.CLOCK2_50      (CLOCK2_50),
		.pic_rst        (pic_rst),
		.i_patch        (i_patch),
		.i_key_busy     (i_key_busy),
		.i_skin_change  (i_skin_change),
		.i_frame_wdone  (i_frame_wdone),
		.i_frame_rdone  (i_frame_rdone),
		.i_gesture_add  (i_gesture_add),
		.i_gesture_sub  (i_gesture_sub),
		.o_view_mode    (o_view_mode),
		.o_write_mode   (o_write_mode),
		.o_varied_color (o_varied_color),
		.o_pic_count    (o_pic_count),
		.o_display_num  (o_display_num),
		.o_wr_base      (o_wr_base),
		.o_rd_base      (o_rd_base),
		.o_snap_req     (o_snap_req),
		.o_reload       (o_reload)
	);

	ui_checker #(
		.SNAP_DELAY (SNAP_DELAY),
		.MAX_PICS   (MAX_PICS)
	) u_checker (
		.i_clk          (CLOCK2_50),
		.i_rst_n        (pic_rst),
		.i_patch        (i_patch),
		.i_key_busy     (i_key_busy),
		.i_skin_change  (i_skin_change),
		.i_frame_wdone  (i_frame_wdone),
		.i_frame_rdone  (i_frame_rdone),
		.i_gesture_add  (i_gesture_add),
		.i_gesture_sub  (i_gesture_sub),
		.i_view_mode    (o_view_mode),
		.i_write_mode   (o_write_mode),
		.i_varied_color (o_varied_color),
		.i_pic_count    (o_pic_count),
		.i_display_num  (o_display_num),
		.i_wr_base      (o_wr_base),
		.i_rd_base      (o_rd_base),
		.i_snap_req     (o_snap_req),
		.i_reload       (o_reload),
		.o_errors       (errors),
		.o_checks       (checks)
	);

	// ==============================
	// Clock and stimulus helpers
	// ==============================

	initial begin
		CLOCK2_50 = 1'b0;
		forever #5 CLOCK2_50 = ~CLOCK2_50;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Weighted patch choice, panel, shot and write touched most
	function automatic int pick_patch(input logic [3:0] sel);
		case (sel)
			4'd0, 4'd1, 4'd2, 4'd3: return gesture_pkg::P_CONTROL;
			4'd4, 4'd5, 4'd6:       return gesture_pkg::P_SHOT;
			4'd7, 4'd8, 4'd9:       return gesture_pkg::P_WRITE;
			4'd10:                  return gesture_pkg::P_CHANGE_MODE;
			4'd11:                  return gesture_pkg::P_CONTROL_BACK;
			4'd12:                  return gesture_pkg::P_WRITE_BACK;
			4'd13:                  return gesture_pkg::P_RED;
			4'd14:                  return gesture_pkg::P_YELLOW;
			default:                return gesture_pkg::P_BLUE;
		endcase
	endfunction

	task automatic drive_random_inputs();
		rng_state = xorshift32(rng_state);
		r_patch   = rng_state;
		rng_state = xorshift32(rng_state);
		r_ctrl    = rng_state;
		i_patch = '0;
		// Sparse touches
		if (r_patch[7:0] < 8'd48)
			i_patch[pick_patch(r_patch[11:8])] = 1'b1;
		// Stray hit anywhere on the overlay
		if (r_patch[23:18] == 6'd0)
			i_patch[int'(r_patch[29:24]) % gesture_pkg::PATCH_W] = 1'b1;
		i_key_busy    = (r_patch[14:12] == 3'd0);
		i_frame_wdone = (r_ctrl[2:0] == 3'd0);
		i_frame_rdone = (r_ctrl[5:3] == 3'd0);
		i_gesture_add = (r_ctrl[7:6] == 2'd0);
		i_gesture_sub = (r_ctrl[9:8] == 2'd0);
		i_skin_change = (r_ctrl[13:10] == 4'd0);
	endtask

	task automatic drive_idle_inputs();
		i_patch       = '0;
		i_key_busy    = 1'b0;
		i_skin_change = 1'b0;
		i_frame_wdone = 1'b0;
		i_frame_rdone = 1'b0;
		i_gesture_add = 1'b0;
		i_gesture_sub = 1'b0;
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		rng_state = 32'd97;
		pic_rst   = 1'b0;
		drive_idle_inputs();
		cycle    = 0;
		snaps    = 0;
		reloads  = 0;
		goal_met = 1'b0;

		repeat (3) @(posedge CLOCK2_50);
		@(negedge CLOCK2_50);
		pic_rst = 1'b1;

		// Random traffic until the album fills and handshakes have run
		while (!goal_met && cycle < RUN_TIMEOUT) begin
			@(negedge CLOCK2_50);
			if (o_snap_req)
				snaps = snaps + 1;
			if (o_reload)
				reloads = reloads + 1;
			drive_random_inputs();
			cycle = cycle + 1;
			goal_met = (cycle >= MIN_CYCLES) && (o_pic_count == 4'(MAX_PICS))
				&& (snaps >= 3) && (reloads >= 4);
		end

		drive_idle_inputs();
		repeat (4) @(negedge CLOCK2_50);

		if (!goal_met)
			$display("Run timed out after %0d cycles before the album filled", cycle);
		$display("cycles %0d checks %0d errors %0d snaps %0d reloads %0d",
			cycle, checks, errors, snaps, reloads);
		if (errors == 0 && goal_met) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/ui_checker.sv ====
`default_nettype none

module ui_checker #(
	parameter int SNAP_DELAY = 16,
	parameter int MAX_PICS   = 7
) (
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic [47:0] i_patch,
	input  logic        i_key_busy,
	input  logic        i_skin_change,
	input  logic        i_frame_wdone,
	input  logic        i_frame_rdone,
	input  logic        i_gesture_add,
	input  logic        i_gesture_sub,
	input  logic [1:0]  i_view_mode,
	input  logic        i_write_mode,
	input  logic [1:0]  i_varied_color,
	input  logic [3:0]  i_pic_count,
	input  logic [3:0]  i_display_num,
	input  logic [22:0] i_wr_base,
	input  logic [22:0] i_rd_base,
	input  logic        i_snap_req,
	input  logic        i_reload,
	output int          o_errors,
	output int          o_checks
);

	// 640x480, two pixels per word
	localparam int FRAME_WORDS = 640 * 480 / 2;

	// Pulse slots: change, control, control back, write, write back, red, yellow, blue, shot
	logic [8:0] m_flag;
	logic [8:0] m_pulse;
	logic [8:0] gated;

	// Reference state
	logic [1:0] m_view;
	logic       m_write;
	logic [1:0] m_color;
	logic       m_counting;
	int         m_remain;
	logic [3:0] m_pics;
	logic       m_wpend;
	logic       m_snap;
	logic [3:0] m_idx;
	logic       m_disp_prev;
	logic       m_rpend;
	logic       m_reload;

	// Per-edge scratch
	logic       disp;
	logic       intf;
	logic       capture;
	logic       step_add;
	logic       step_sub;
	logic [3:0] last_idx;

	// ==============================
	// Reference model
	// ==============================

	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			m_flag      <= '0;
			m_pulse     <= '0;
			m_view      <= '0;
			m_write     <= 1'b0;
			m_color     <= gesture_pkg::COLOR_RED;
			m_counting  <= 1'b0;
			m_remain    <= 0;
			m_pics      <= '0;
			m_wpend     <= 1'b0;
			m_snap      <= 1'b0;
			m_idx       <= '0;
			m_disp_prev <= 1'b0;
			m_rpend     <= 1'b0;
			m_reload    <= 1'b0;
		end else begin
			// Touch seen only with keys idle
			gated = {i_patch[40], i_patch[4], i_patch[3], i_patch[2], i_patch[24],
				i_patch[32], i_patch[6], i_patch[7], i_patch[0]} & {9{~i_key_busy}};
			m_flag  <= gated;
			m_pulse <= gated & ~m_flag;

			disp = m_view[gesture_pkg::MODE_DISPLAY];
			intf = m_view[gesture_pkg::MODE_INTERFACE];

			// Display bit
			if (disp && i_skin_change)
				m_view[gesture_pkg::MODE_DISPLAY] <= 1'b0;
			else if (!disp && m_pulse[0] && m_pics != 0)
				m_view[gesture_pkg::MODE_DISPLAY] <= 1'b1;
			// Interface bit
			if (!intf && m_pulse[1])
				m_view[gesture_pkg::MODE_INTERFACE] <= 1'b1;
			else if (intf && m_pulse[2])
				m_view[gesture_pkg::MODE_INTERFACE] <= 1'b0;

			// Write mode, cleared whenever the panel opens or closes
			if (m_pulse[1] || (intf && m_pulse[2]))
				m_write <= 1'b0;
			else if (intf && !disp && (m_write ? m_pulse[4] : m_pulse[3]))
				m_write <= !m_write;

			if (m_write && !disp) begin
				if (m_pulse[5])
					m_color <= gesture_pkg::COLOR_RED;
				else if (m_pulse[6])
					m_color <= gesture_pkg::COLOR_YELLOW;
				else if (m_pulse[7])
					m_color <= gesture_pkg::COLOR_BLUE;
			end

			// Shot timer counts down to the capture
			capture = 1'b0;
			if (m_pulse[8] && intf && !disp) begin
				m_counting <= 1'b1;
				m_remain   <= SNAP_DELAY;
			end else if (m_counting) begin
				if (m_remain == 0) begin
					capture = 1'b1;
					m_counting <= 1'b0;
				end else begin
					m_remain <= m_remain - 1;
				end
			end
			if (capture && m_pics < MAX_PICS) begin
				m_pics  <= m_pics + 4'd1;
				m_wpend <= 1'b1;
			end else if (i_frame_wdone) begin
				m_wpend <= 1'b0;
			end
			m_snap <= m_wpend && i_frame_wdone;

			// Browsing
			step_add = disp && i_gesture_add;
			step_sub = disp && i_gesture_sub && !i_gesture_add;
			last_idx = m_pics - 4'd1;
			if (step_add)
				m_idx <= (m_idx == last_idx) ? 4'd0 : m_idx + 4'd1;
			else if (step_sub)
				m_idx <= (m_idx == 4'd0) ? last_idx : m_idx - 4'd1;

			m_disp_prev <= disp;
			if (step_add || step_sub || (disp != m_disp_prev))
				m_rpend <= 1'b1;
			else if (i_frame_rdone)
				m_rpend <= 1'b0;
			m_reload <= m_rpend && i_frame_rdone;
		end
	end

	// ==============================
	// Output comparison
	// ==============================

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		o_checks = o_checks + 1;
		if (got !== exp) begin
			o_errors = o_errors + 1;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	initial begin
		o_errors = 0;
		o_checks = 0;
	end

	// Outputs settled half a cycle after the edge
	always @(negedge i_clk) begin
		int rd_sel;
		if (i_rst_n) begin
			rd_sel = m_view[gesture_pkg::MODE_DISPLAY] ? int'(m_idx) : int'(m_pics);
			compare_value("o_view_mode", 32'(i_view_mode), 32'(m_view));
			compare_value("o_write_mode", 32'(i_write_mode), 32'(m_write));
			compare_value("o_varied_color", 32'(i_varied_color), 32'(m_color));
			compare_value("o_pic_count", 32'(i_pic_count), 32'(m_pics));
			compare_value("o_display_num", 32'(i_display_num), 32'(m_idx));
			compare_value("o_wr_base", 32'(i_wr_base), int'(m_pics) * FRAME_WORDS);
			compare_value("o_rd_base", 32'(i_rd_base), rd_sel * FRAME_WORDS);
			compare_value("o_snap_req", 32'(i_snap_req), 32'(m_snap));
			compare_value("o_reload", 32'(i_reload), 32'(m_reload));
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the gesture UI testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module tb_gesture_ui -o sim_gesture_ui
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_gesture_ui)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
	exit 0
fi
exit 1
